// File: verilog/uart_pkg.sv
`default_nettype none

package uart_pkg;

  // Serial bit timing.
  localparam int clks_per_bit     = 434;
  localparam int half_bit         = 217;  // Start edge to the middle of the start bit.
  localparam int frame_gap        = 16;   // Idle line cycles between the two write frames.
  localparam int rsp_timeout_bits = 32;   // Bit times allowed for a read reply.

  localparam int rsp_timeout_cycles = rsp_timeout_bits * clks_per_bit;

  // Counter widths.
  localparam int bit_cnt_w = $clog2(clks_per_bit);
  localparam int gap_cnt_w = $clog2(frame_gap);
  localparam int tmo_cnt_w = $clog2(rsp_timeout_cycles);

  // Host command, write flag in bit 15.
  typedef struct packed {
    logic       write;
    logic [6:0] addr;
    logic [7:0] data;
  } cmd_t;

  // Read response.
  typedef struct packed {
    logic [7:0] data;
    logic       parity_err;
    logic       timeout;
  } rsp_t;

  typedef enum logic [2:0] {
    idle,
    send_addr,
    gap,
    send_data,
    wait_reply,
    respond
  } ctrl_state_t;

endpackage

`default_nettype wire

// File: verilog/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tx_start,
  input  logic [7:0] tx_byte,
  output logic       tx,
  output logic       tx_busy
);

  import uart_pkg::*;

  logic [bit_cnt_w-1:0] bit_cnt;
  logic [3:0]           bit_idx;   // 0 start, 1 to 8 data, 9 parity, 10 stop.
  logic [9:0]           frame_sr;
  logic                 bit_end;

  assign bit_end = (bit_cnt == bit_cnt_w'(clks_per_bit - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tx      <= 1'b1;
      tx_busy <= 1'b0;
      bit_cnt <= '0;
      bit_idx <= '0;
    end
    else if (!tx_busy)
    begin
      if (tx_start)
      begin
        tx      <= 1'b0;  // Start bit goes out in the next cycle.
        tx_busy <= 1'b1;
        bit_cnt <= '0;
        bit_idx <= '0;
      end
    end
    else if (bit_end)
    begin
      bit_cnt <= '0;
      if (bit_idx == 4'd10)
      begin
        tx_busy <= 1'b0;  // Line stays high after the stop bit.
      end
      else
      begin
        tx      <= frame_sr[0];
        bit_idx <= bit_idx + 4'd1;
      end
    end
    else
    begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  // Holds data, even parity and stop, shifted out LSB first.
  always_ff @(posedge clk)
  begin
    if (tx_start && !tx_busy)
    begin
      frame_sr <= {1'b1, ^tx_byte, tx_byte};
    end
    else if (tx_busy && bit_end)
    begin
      frame_sr <= {1'b1, frame_sr[9:1]};
    end
  end

endmodule

`default_nettype wire

// File: verilog/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rx,
  output logic       rx_vld,
  output logic [7:0] rx_byte,
  output logic       rx_parity_err
);

  import uart_pkg::*;

  logic                 rx_s1;
  logic                 rx_s2;
  logic                 rx_prev;
  logic                 busy;
  logic [bit_cnt_w-1:0] cnt;
  logic [3:0]           bit_idx;
  logic [7:0]           data_sr;
  logic                 parity_bit;
  logic                 sample;

  // The start bit is checked half a bit in, every later bit one full bit apart.
  assign sample = (bit_idx == 4'd0) ? (cnt == bit_cnt_w'(half_bit - 1))
                                    : (cnt == bit_cnt_w'(clks_per_bit - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_s1   <= 1'b1;
      rx_s2   <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_s1   <= rx;
      rx_s2   <= rx_s1;
      rx_prev <= rx_s2;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy    <= 1'b0;
      cnt     <= '0;
      bit_idx <= '0;
      rx_vld  <= 1'b0;
    end
    else
    begin
      rx_vld <= 1'b0;
      if (!busy)
      begin
        if (rx_prev && !rx_s2)
        begin
          busy    <= 1'b1;
          cnt     <= bit_cnt_w'(1);  // Edge cycle counts as the first one.
          bit_idx <= '0;
        end
      end
      else if (sample)
      begin
        cnt <= '0;
        if (bit_idx == 4'd0 && rx_s2)
        begin
          busy <= 1'b0;  // Glitch, not a start bit.
        end
        else if (bit_idx == 4'd10)
        begin
          busy   <= 1'b0;
          rx_vld <= 1'b1;
        end
        else
        begin
          bit_idx <= bit_idx + 4'd1;
        end
      end
      else
      begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (busy && sample)
    begin
      if (bit_idx >= 4'd1 && bit_idx <= 4'd8)
      begin
        data_sr <= {rx_s2, data_sr[7:1]};  // LSB arrives first.
      end
      if (bit_idx == 4'd9)
      begin
        parity_bit <= rx_s2;
      end
      if (bit_idx == 4'd10)
      begin
        rx_byte       <= data_sr;
        rx_parity_err <= ^{data_sr, parity_bit};
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/uart_cmd_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_ctrl (
  input  logic           clk,
  input  logic           rst_n,
  input  uart_pkg::cmd_t cmd,
  input  logic           cmd_vld,
  output logic           cmd_rdy,
  output uart_pkg::rsp_t rsp,
  output logic           rsp_vld,
  output logic           tx_start,
  output logic [7:0]     tx_byte,
  input  logic           tx_busy,
  input  logic           rx_vld,
  input  logic [7:0]     rx_byte,
  input  logic           rx_parity_err
);

  import uart_pkg::*;

  ctrl_state_t          state;
  cmd_t                 cmd_q;
  logic [gap_cnt_w-1:0] gap_cnt;
  logic [tmo_cnt_w-1:0] tmo_cnt;
  logic                 frame_done;
  logic                 tmo_hit;
  logic                 accept;

  assign cmd_rdy = (state == idle);
  assign rsp_vld = (state == respond);
  assign accept  = cmd_vld && cmd_rdy;

  // Address byte carries the write flag in bit 7.
  assign tx_byte = (state == send_data) ? cmd_q.data : {cmd_q.write, cmd_q.addr};

  // The serializer raises tx_busy one cycle after the start pulse.
  assign frame_done = !tx_busy && !tx_start;

  assign tmo_hit = (tmo_cnt == tmo_cnt_w'(rsp_timeout_cycles - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= idle;
      tx_start <= 1'b0;
      gap_cnt  <= '0;
      tmo_cnt  <= '0;
    end
    else
    begin
      tx_start <= 1'b0;
      case (state)
        idle:
        begin
          if (accept)
          begin
            state    <= send_addr;
            tx_start <= 1'b1;
          end
        end
        send_addr:
        begin
          if (frame_done)
          begin
            gap_cnt <= '0;
            tmo_cnt <= '0;
            state   <= cmd_q.write ? gap : wait_reply;
          end
        end
        gap:
        begin
          // The busy check and the start pulse cover the last two idle cycles.
          if (gap_cnt == gap_cnt_w'(frame_gap - 3))
          begin
            state    <= send_data;
            tx_start <= 1'b1;
          end
          else
          begin
            gap_cnt <= gap_cnt + 1'b1;
          end
        end
        send_data:
        begin
          if (frame_done)
          begin
            state <= idle;
          end
        end
        wait_reply:
        begin
          if (rx_vld || tmo_hit)
          begin
            state <= respond;
          end
          else
          begin
            tmo_cnt <= tmo_cnt + 1'b1;
          end
        end
        respond:
        begin
          state <= idle;
        end
        default:
        begin
          state <= idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      cmd_q <= cmd;
    end
    if (state == wait_reply)
    begin
      if (rx_vld)
      begin
        rsp <= '{data: rx_byte, parity_err: rx_parity_err, timeout: 1'b0};
      end
      else if (tmo_hit)
      begin
        rsp <= '{data: 8'h00, parity_err: 1'b0, timeout: 1'b1};  // No reply seen.
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/uart_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module uart_bridge (
  input  logic           clk,
  input  logic           rst_n,
  input  uart_pkg::cmd_t cmd,
  input  logic           cmd_vld,
  output logic           cmd_rdy,
  output uart_pkg::rsp_t rsp,
  output logic           rsp_vld,
  input  logic           rx,
  output logic           tx
);

  logic       tx_start;
  logic [7:0] tx_byte;
  logic       tx_busy;
  logic       rx_vld;
  logic [7:0] rx_byte;
  logic       rx_parity_err;

  uart_cmd_ctrl uart_cmd_ctrl_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .cmd           (cmd),
    .cmd_vld       (cmd_vld),
    .cmd_rdy       (cmd_rdy),
    .rsp           (rsp),
    .rsp_vld       (rsp_vld),
    .tx_start      (tx_start),
    .tx_byte       (tx_byte),
    .tx_busy       (tx_busy),
    .rx_vld        (rx_vld),
    .rx_byte       (rx_byte),
    .rx_parity_err (rx_parity_err)
  );

  uart_tx uart_tx_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_busy  (tx_busy)
  );

  // Runs all the time, the controller only listens in wait_reply.
  uart_rx uart_rx_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .rx            (rx),
    .rx_vld        (rx_vld),
    .rx_byte       (rx_byte),
    .rx_parity_err (rx_parity_err)
  );

endmodule

`default_nettype wire

// File: testbench/uart_device_model.sv
`timescale 1ns/1ps
`default_nettype none

module uart_device_model (
  input  logic clk,
  input  logic rst_n,
  input  logic tx,
  output logic rx,
  input  logic bad_parity,
  input  logic silent,
  output int   frame_errors,
  output int   min_gap
);

  import uart_pkg::*;

  logic [7:0] mem [0:127];
  logic [7:0] addr_byte;
  logic [7:0] data_byte;
  int         idle_len;

  // Bits are sampled on the falling clock edge, half a cycle away from any tx change.
  task automatic get_frame(output logic [7:0] b, output int idle_cycles);
    logic p;
    idle_cycles = 0;
    do
    begin
      @(negedge clk);
      idle_cycles++;
    end
    while (tx !== 1'b0);
    repeat (half_bit) @(negedge clk);
    if (tx !== 1'b0)
    begin
      frame_errors++;  // Start bit did not hold.
    end
    for (int i = 0; i < 8; i++)
    begin
      repeat (clks_per_bit) @(negedge clk);
      b[i] = tx;
    end
    repeat (clks_per_bit) @(negedge clk);
    p = tx;
    if (^{b, p} !== 1'b0)
    begin
      frame_errors++;
    end
    repeat (clks_per_bit) @(negedge clk);
    if (tx !== 1'b1)
    begin
      frame_errors++;
    end
  endtask

  // The stop bit is left as idle line so the next address frame is not missed.
  task automatic send_frame(input logic [7:0] b);
    logic [9:0] bits;
    bits = {^b ^ bad_parity, b, 1'b0};
    for (int i = 0; i < 10; i++)
    begin
      rx <= bits[i];
      repeat (clks_per_bit) @(posedge clk);
    end
    rx <= 1'b1;
  endtask

  initial
  begin
    rx           = 1'b1;
    frame_errors = 0;
    min_gap      = 32'h7fff_ffff;
    for (int i = 0; i < 128; i++)
    begin
      mem[i] = 8'h00;
    end
    wait (rst_n === 1'b1);
    forever
    begin
      get_frame(addr_byte, idle_len);
      if (addr_byte[7])
      begin
        get_frame(data_byte, idle_len);
        mem[addr_byte[6:0]] = data_byte;
        // The count starts mid stop bit of the address frame.
        if (idle_len - (clks_per_bit - half_bit) < min_gap)
        begin
          min_gap = idle_len - (clks_per_bit - half_bit);
        end
      end
      else if (!silent)
      begin
        repeat ((int'($urandom % 8) + 1) * clks_per_bit) @(posedge clk);
        send_frame(mem[addr_byte[6:0]]);
      end
    end
  end

endmodule

`default_nettype wire

// File: testbench/tb_uart_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module tb_uart_bridge;

  import uart_pkg::*;

  localparam int     num_cmds    = 50;
  localparam longint watchdog_ns = longint'(num_cmds) * 60 * clks_per_bit * 100;

  logic       clk;
  logic       rst_n;
  cmd_t       cmd;
  logic       cmd_vld;
  logic       cmd_rdy;
  rsp_t       rsp;
  logic       rsp_vld;
  logic       rx;
  logic       tx;
  logic       bad_parity;
  logic       silent;
  int         frame_errors;
  int         min_gap;
  logic [7:0] exp_mem [0:127];

  uart_bridge uart_bridge_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .cmd     (cmd),
    .cmd_vld (cmd_vld),
    .cmd_rdy (cmd_rdy),
    .rsp     (rsp),
    .rsp_vld (rsp_vld),
    .rx      (rx),
    .tx      (tx)
  );

  uart_device_model uart_device_model_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .tx           (tx),
    .rx           (rx),
    .bad_parity   (bad_parity),
    .silent       (silent),
    .frame_errors (frame_errors),
    .min_gap      (min_gap)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial
  begin
    #(watchdog_ns);
    $display("Timeout: the tests did not finish within %0d ns.", watchdog_ns);
    abort_run();
  end

  task automatic abort_run();
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped at the first failure.");
  endtask

  task automatic check_bit(input string name, input logic got, input logic expected);
    if (got !== expected)
    begin
      $display("Error at %0t: %s is %b, expected %b", $time, name, got, expected);
      abort_run();
    end
  endtask

  task automatic check_rsp(input rsp_t got, input rsp_t expected);
    if (got !== expected)
    begin
      $display("Error at %0t: rsp is %h, expected %h", $time, got, expected);
      abort_run();
    end
  endtask

  task automatic issue_cmd(input cmd_t c);
    @(posedge clk);
    cmd     <= c;
    cmd_vld <= 1'b1;
    @(negedge clk);
    while (!cmd_rdy) @(negedge clk);
    @(posedge clk);  // Accepting edge.
    cmd_vld <= 1'b0;
  endtask

  task automatic write_cmd(input logic [6:0] a, input logic [7:0] d);
    cmd_t c;
    c.write = 1'b1;
    c.addr  = a;
    c.data  = d;
    issue_cmd(c);
    exp_mem[a] = d;
  endtask

  task automatic read_check(input logic [6:0] a, input rsp_t expected);
    cmd_t c;
    c.write = 1'b0;
    c.addr  = a;
    c.data  = 8'h00;
    issue_cmd(c);
    @(negedge clk);
    while (!rsp_vld) @(negedge clk);
    check_rsp(rsp, expected);
    @(negedge clk);
    check_bit("rsp_vld", rsp_vld, 1'b0);  // The response is a one-cycle pulse.
    check_bit("cmd_rdy", cmd_rdy, 1'b1);
  endtask

  task automatic test_reset();
    @(negedge clk);
    check_bit("cmd_rdy", cmd_rdy, 1'b1);
    check_bit("rsp_vld", rsp_vld, 1'b0);
    check_bit("tx", tx, 1'b1);
  endtask

  task automatic test_write_read();
    logic [6:0] addrs [20];
    logic       used [128];
    logic [6:0] tmp;
    int         j;
    int         found;
    for (int i = 0; i < 128; i++)
    begin
      used[i] = 1'b0;
    end
    for (int i = 0; i < 20; i++)
    begin
      addrs[i]       = 7'($urandom);
      used[addrs[i]] = 1'b1;
      write_cmd(addrs[i], 8'($urandom));
    end
    for (int i = 19; i > 0; i--)
    begin
      j        = int'($urandom % (i + 1));
      tmp      = addrs[i];
      addrs[i] = addrs[j];
      addrs[j] = tmp;
    end
    for (int i = 0; i < 20; i++)
    begin
      read_check(addrs[i], '{data: exp_mem[addrs[i]], parity_err: 1'b0, timeout: 1'b0});
    end
    found = 0;
    for (int a = 0; a < 128; a++)
    begin
      if (!used[a] && found < 2)
      begin
        read_check(7'(a), '{data: 8'h00, parity_err: 1'b0, timeout: 1'b0});
        found++;
      end
    end
  endtask

  task automatic test_frames();
    if (frame_errors != 0)
    begin
      $display("The device model saw %0d bad frames on tx.", frame_errors);
      abort_run();
    end
    if (min_gap < frame_gap)
    begin
      $display("The gap between write frames was only %0d cycles.", min_gap);
      abort_run();
    end
  endtask

  task automatic test_parity();
    write_cmd(7'h2a, 8'ha5);
    @(posedge clk);
    bad_parity <= 1'b1;
    read_check(7'h2a, '{data: 8'ha5, parity_err: 1'b1, timeout: 1'b0});
    @(posedge clk);
    bad_parity <= 1'b0;
  endtask

  task automatic test_timeout();
    @(posedge clk);
    silent <= 1'b1;
    read_check(7'h2a, '{data: 8'h00, parity_err: 1'b0, timeout: 1'b1});
    @(posedge clk);
    silent <= 1'b0;
    read_check(7'h2a, '{data: exp_mem[7'h2a], parity_err: 1'b0, timeout: 1'b0});
  endtask

  task automatic test_back_pressure();
    int low_cycles;
    @(posedge clk);
    cmd     <= '{write: 1'b1, addr: 7'h55, data: 8'h3c};
    cmd_vld <= 1'b1;
    @(negedge clk);
    while (!cmd_rdy) @(negedge clk);
    @(posedge clk);
    cmd <= '{write: 1'b1, addr: 7'h56, data: 8'hc3};  // Valid stays high.
    low_cycles = 0;
    @(negedge clk);
    while (!cmd_rdy)
    begin
      low_cycles++;
      @(negedge clk);
    end
    if (low_cycles < 2 * 11 * clks_per_bit + frame_gap)
    begin
      $display("cmd_rdy rose after %0d cycles, before the first write ended.", low_cycles);
      abort_run();
    end
    @(posedge clk);
    cmd_vld <= 1'b0;
    @(negedge clk);
    check_bit("cmd_rdy", cmd_rdy, 1'b0);  // The second command was taken once.
    while (!cmd_rdy) @(negedge clk);
    exp_mem[7'h55] = 8'h3c;
    exp_mem[7'h56] = 8'hc3;
    read_check(7'h55, '{data: exp_mem[7'h55], parity_err: 1'b0, timeout: 1'b0});
    read_check(7'h56, '{data: exp_mem[7'h56], parity_err: 1'b0, timeout: 1'b0});
  endtask

  initial
  begin
    void'($urandom(32'h6320_ab68));
    rst_n      = 1'b0;
    cmd        = '0;
    cmd_vld    = 1'b0;
    bad_parity = 1'b0;
    silent     = 1'b0;
    for (int i = 0; i < 128; i++)
    begin
      exp_mem[i] = 8'h00;
    end
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    test_reset();
    test_write_read();
    test_frames();
    test_parity();
    test_timeout();
    test_back_pressure();
    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
verilog/uart_pkg.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_cmd_ctrl.sv
verilog/uart_bridge.sv
testbench/uart_device_model.sv
testbench/tb_uart_bridge.sv

// File: run_sim.sh
#!/bin/sh
# Compile with Verilator, run, and look for the pass line in the output.
cd "$(dirname "$0")" \
  && verilator --binary --timing --timescale 1ns/1ps -f sim.f \
       --top-module tb_uart_bridge -o tb_uart_bridge \
  && ./obj_dir/tb_uart_bridge | tee /dev/stderr | grep -q "NO ERRORS" \
  && echo "Simulation passed." \
  || { echo "Simulation failed."; exit 1; }
